/* design/predecodePkg.sv */
`default_nettype none

package predecodePkg;

  // Bundle geometry
  localparam int ParcelW = 16;
  localparam int NumParcels = 15;
  localparam int BundleW = 256;
  localparam int EndBase = 240;
  localparam int WindowParcels = 4;
  localparam int OffW = 4;
  localparam int LenW = 2;

  // Class bit positions
  localparam int ClsW = 4;
  localparam int ClsAlu = 0;
  localparam int ClsLoad = 1;
  localparam int ClsStore = 2;
  localparam int ClsJump = 3;

  // Opcode byte patterns
  localparam logic [3:0] OpCondJumpHi = 4'b1010;
  localparam logic [7:0] OpSelfTestJumpA = 8'd178;
  localparam logic [7:0] OpSelfTestJumpB = 8'd179;
  localparam logic [7:0] OpLongCondJump = 8'd180;
  localparam logic [7:0] OpUncondJump = 8'd181;
  localparam logic [7:0] OpIndirJump = 8'd182;
  localparam logic [2:0] OpMemGroup = 3'b010;

  typedef struct packed {
    logic [WindowParcels*ParcelW-1:0] window;
    logic [ClsW-1:0] cls;
    logic [LenW-1:0] len;
    logic [OffW-1:0] off;
  } instrSlotT;

  typedef struct packed {
    logic [WindowParcels*ParcelW-1:0] window;
    logic [OffW-1:0] off;
  } jumpSlotT;

endpackage

`default_nettype wire

/* design/parcelBoundary.sv */
`timescale 1ns/1ns
`default_nettype none

module parcelBoundary (
  input  logic clk,
  input  logic rstN,
  input  logic bundleValid,
  input  logic [predecodePkg::BundleW-1:0] bundle,
  input  logic [predecodePkg::OffW-1:0] startOff,
  output logic [predecodePkg::NumParcels-1:0] startVec,
  output logic [predecodePkg::NumParcels-1:0][predecodePkg::LenW-1:0] lenVec,
  output logic startError,
  output logic outValid
);
  import predecodePkg::*;

  // End flags, padded with ones past the last parcel
  logic [NumParcels+1:0] endVec;
  logic [NumParcels-1:0] startRaw;

  // Parcel 14 always ends
  assign endVec = {2'b11, 1'b1, bundle[EndBase +: NumParcels-1]};

  // A parcel starts after an end, parcel 0 always
  assign startRaw = {endVec[NumParcels-2:0], 1'b1};

  for (genvar k = 0; k < NumParcels; k++) begin : genParcel
    assign startVec[k] = startRaw[k] && (OffW'(k) >= startOff);

    // Length minus one, capped at four parcels
    assign lenVec[k] = endVec[k]   ? LenW'(0) :
                       endVec[k+1] ? LenW'(1) :
                       endVec[k+2] ? LenW'(2) : LenW'(3);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      startError <= 1'b0;
      outValid <= 1'b0;
    end else begin
      outValid <= bundleValid;
      if (bundleValid) begin
        // No parcel can start at offset 15
        startError <= (startOff == OffW'(NumParcels));
      end
    end
  end

endmodule

`default_nettype wire

/* design/parcelClassifier.sv */
`timescale 1ns/1ns
`default_nettype none

module parcelClassifier (
  input  logic [predecodePkg::BundleW-1:0] bundle,
  input  logic [predecodePkg::NumParcels-1:0][predecodePkg::LenW-1:0] lenVec,
  input  logic [predecodePkg::NumParcels-1:0] startVec,
  output predecodePkg::instrSlotT [predecodePkg::NumParcels-1:0] instrPay,
  output predecodePkg::jumpSlotT [predecodePkg::NumParcels-1:0] jumpPay,
  output logic [predecodePkg::NumParcels-1:0] jumpSel
);
  import predecodePkg::*;

  localparam int WinW = WindowParcels * ParcelW;
  localparam int PadW = WinW - ParcelW;

  // Parcels past the last one read as zero
  logic [NumParcels*ParcelW+PadW-1:0] padded;
  logic [NumParcels-1:0] jumpVec;

  assign padded = {{PadW{1'b0}}, bundle[NumParcels*ParcelW-1:0]};

  for (genvar k = 0; k < NumParcels; k++) begin : genParcel
    logic [7:0] opcode;
    logic [ClsW-1:0] cls;
    logic [WinW-1:0] window;

    assign opcode = bundle[k*ParcelW +: 8];
    assign window = padded[k*ParcelW +: WinW];

    assign cls[ClsAlu] = (opcode[7:5] == 3'b000) || (opcode[7:3] == 5'b00100);
    assign cls[ClsLoad] = (opcode[7:5] == OpMemGroup) && !opcode[0];
    assign cls[ClsStore] = (opcode[7:5] == OpMemGroup) && opcode[0];
    assign cls[ClsJump] = (opcode[7:4] == OpCondJumpHi) ||
                          (opcode == OpSelfTestJumpA) || (opcode == OpSelfTestJumpB) ||
                          (opcode == OpLongCondJump) || (opcode == OpUncondJump) ||
                          (opcode == OpIndirJump);

    assign jumpVec[k] = cls[ClsJump];

    assign instrPay[k] = '{window: window, cls: cls, len: lenVec[k], off: OffW'(k)};
    assign jumpPay[k] = '{window: window, off: OffW'(k)};
  end

  // Only true starts count as jumps
  assign jumpSel = jumpVec & startVec;

endmodule

`default_nettype wire

/* design/slotCompactor.sv */
`timescale 1ns/1ns
`default_nettype none

module slotCompactor #(
  parameter int NumSlots = 8,
  parameter type SlotT = logic [7:0]
) (
  input  logic clk,
  input  logic rstN,
  input  logic load,
  input  logic [predecodePkg::NumParcels-1:0] sel,
  input  SlotT [predecodePkg::NumParcels-1:0] pay,
  output SlotT [NumSlots-1:0] slots,
  output logic [NumSlots-1:0] slotEn,
  output logic overflow
);
  import predecodePkg::*;

  localparam int CntW = $clog2(NumParcels + 1);

  // Selected parcels below each parcel
  logic [NumParcels-1:0][CntW-1:0] cntBefore;
  logic [CntW-1:0] selTotal;
  SlotT [NumSlots-1:0] slotsNext;
  logic [NumSlots-1:0] enNext;
  logic overflowNext;

  always_comb begin
    logic [CntW-1:0] cnt;
    cnt = '0;
    for (int k = 0; k < NumParcels; k++) begin
      cntBefore[k] = cnt;
      cnt = cnt + CntW'(sel[k]);
    end
    selTotal = cnt;
  end

  // Slot i takes the parcel with exactly i selected parcels before it
  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      slotsNext[i] = '0;
      enNext[i] = selTotal > CntW'(i);
      for (int k = 0; k < NumParcels; k++) begin
        if (sel[k] && (cntBefore[k] == CntW'(i))) begin
          slotsNext[i] = pay[k];
        end
      end
    end
  end

  // Extra selections are dropped, the first ones still fill the slots
  assign overflowNext = selTotal > CntW'(NumSlots);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slots <= '0;
      slotEn <= '0;
      overflow <= 1'b0;
    end else if (load) begin
      slots <= slotsNext;
      slotEn <= enNext;
      overflow <= overflowNext;
    end
  end

endmodule

`default_nettype wire

/* design/bundlePredecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module bundlePredecoder #(
  parameter int NumInstrSlots = 8,
  parameter int NumJumpSlots = 2
) (
  input  logic clk,
  input  logic rstN,
  input  logic bundleValid,
  input  logic [predecodePkg::BundleW-1:0] bundle,
  input  logic [predecodePkg::OffW-1:0] startOff,
  output logic outValid,
  output predecodePkg::instrSlotT [NumInstrSlots-1:0] instrSlots,
  output logic [NumInstrSlots-1:0] instrEn,
  output predecodePkg::jumpSlotT [NumJumpSlots-1:0] jumpSlots,
  output logic [NumJumpSlots-1:0] jumpEn,
  output logic startError,
  output logic instrOverflow,
  output logic jumpOverflow
);
  import predecodePkg::*;

  logic [NumParcels-1:0] startVec;
  logic [NumParcels-1:0][LenW-1:0] lenVec;
  instrSlotT [NumParcels-1:0] instrPay;
  jumpSlotT [NumParcels-1:0] jumpPay;
  logic [NumParcels-1:0] jumpSel;

  parcelBoundary boundary (
    .clk(clk),
    .rstN(rstN),
    .bundleValid(bundleValid),
    .bundle(bundle),
    .startOff(startOff),
    .startVec(startVec),
    .lenVec(lenVec),
    .startError(startError),
    .outValid(outValid)
  );

  parcelClassifier classifier (
    .bundle(bundle),
    .lenVec(lenVec),
    .startVec(startVec),
    .instrPay(instrPay),
    .jumpPay(jumpPay),
    .jumpSel(jumpSel)
  );

  // Every start goes to an instruction slot
  slotCompactor #(
    .NumSlots(NumInstrSlots),
    .SlotT(instrSlotT)
  ) instrCompactor (
    .clk(clk),
    .rstN(rstN),
    .load(bundleValid),
    .sel(startVec),
    .pay(instrPay),
    .slots(instrSlots),
    .slotEn(instrEn),
    .overflow(instrOverflow)
  );

  // Jump starts only
  slotCompactor #(
    .NumSlots(NumJumpSlots),
    .SlotT(jumpSlotT)
  ) jumpCompactor (
    .clk(clk),
    .rstN(rstN),
    .load(bundleValid),
    .sel(jumpSel),
    .pay(jumpPay),
    .slots(jumpSlots),
    .slotEn(jumpEn),
    .overflow(jumpOverflow)
  );

endmodule

`default_nettype wire

/* sim/predecoderTb.sv */
`timescale 1ns/1ns
`default_nettype none

module predecoderTb;
  import predecodePkg::*;

  localparam int NumInstrSlots = 8;
  localparam int NumJumpSlots = 2;
  localparam int NumEntries = 12;
  localparam int TimeoutCycles = NumEntries * 3 + 20;
  localparam int CmpW = 1024;

  logic clk = 1'b0;
  logic rstN;
  logic bundleValid;
  logic [BundleW-1:0] bundle;
  logic [OffW-1:0] startOff;
  logic outValid;
  instrSlotT [NumInstrSlots-1:0] instrSlots;
  logic [NumInstrSlots-1:0] instrEn;
  jumpSlotT [NumJumpSlots-1:0] jumpSlots;
  logic [NumJumpSlots-1:0] jumpEn;
  logic startError;
  logic instrOverflow;
  logic jumpOverflow;

  // Stimulus table and expected results
  logic [BundleW-1:0] tabBundle [NumEntries];
  int tabOff [NumEntries];
  instrSlotT [NumInstrSlots-1:0] expInstrSlots [NumEntries];
  logic [NumInstrSlots-1:0] expInstrEn [NumEntries];
  jumpSlotT [NumJumpSlots-1:0] expJumpSlots [NumEntries];
  logic [NumJumpSlots-1:0] expJumpEn [NumEntries];
  logic expStartError [NumEntries];
  logic expInstrOverflow [NumEntries];
  logic expJumpOverflow [NumEntries];

  int cycleCount = 0;

  bundlePredecoder #(
    .NumInstrSlots(NumInstrSlots),
    .NumJumpSlots(NumJumpSlots)
  ) dut (
    .clk(clk),
    .rstN(rstN),
    .bundleValid(bundleValid),
    .bundle(bundle),
    .startOff(startOff),
    .outValid(outValid),
    .instrSlots(instrSlots),
    .instrEn(instrEn),
    .jumpSlots(jumpSlots),
    .jumpEn(jumpEn),
    .startError(startError),
    .instrOverflow(instrOverflow),
    .jumpOverflow(jumpOverflow)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run went past %0d cycles", TimeoutCycles);
      $display("CHECKS FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic checkValue(input string name, input logic [CmpW-1:0] expected,
                            input logic [CmpW-1:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [BundleW-1:0] makeBundle(
    input logic [NumParcels-1:0][ParcelW-1:0] parcels,
    input logic [NumParcels-1:0] ends
  );
    return {1'b0, ends, parcels};
  endfunction

  task automatic buildTable();
    logic [NumParcels-1:0][ParcelW-1:0] parcels;
    logic [NumParcels*8-1:0] mixedOps;
    logic [NumParcels*8-1:0] sweepOps;
    mixedOps = 120'h3F_FF_60_80_AF_B6_B5_B4_B3_B2_A0_43_42_21_05;
    sweepOps = 120'hA9_B7_B1_5D_44_28_27_1F_A5_A5_A5_A5_A5_A5_A5;

    // Lengths 1 to 4, one start per class
    for (int k = 0; k < NumParcels; k++) begin
      parcels[k] = {8'(8'h10 + k), 8'h80};
    end
    parcels[0][7:0] = 8'h05;
    parcels[1][7:0] = 8'h42;
    parcels[3][7:0] = 8'hA3;
    parcels[6][7:0] = 8'h21;
    parcels[10][7:0] = 8'hB5;
    parcels[11][7:0] = 8'h43;
    tabBundle[0] = makeBundle(parcels, 15'h0625);
    tabOff[0] = 0;
    // Jump at parcel 3 falls below the offset
    tabBundle[1] = tabBundle[0];
    tabOff[1] = 4;

    // Every parcel ends, too many starts and jumps
    for (int k = 0; k < NumParcels; k++) begin
      parcels[k] = {8'(8'hC0 + k), mixedOps[k*8 +: 8]};
    end
    tabBundle[2] = makeBundle(parcels, '1);
    tabOff[2] = 0;
    tabBundle[3] = tabBundle[2];
    tabOff[3] = 15;

    // Exactly eight starts
    for (int k = 0; k < NumParcels; k++) begin
      parcels[k] = {8'(8'h3C ^ k), sweepOps[k*8 +: 8]};
    end
    tabBundle[4] = makeBundle(parcels, '1);
    tabOff[4] = 7;

    // No end markers, top bit set
    for (int k = 0; k < NumParcels; k++) begin
      parcels[k] = {8'(k), 8'h90};
    end
    tabBundle[5] = makeBundle(parcels, '0);
    tabBundle[5][BundleW-1] = 1'b1;
    tabOff[5] = 0;

    for (int e = 6; e < NumEntries; e++) begin
      for (int k = 0; k < NumParcels; k++) begin
        parcels[k] = 16'($urandom);
        // Bias toward known opcodes
        if ($urandom % 2 == 0) begin
          parcels[k][7:0] = mixedOps[($urandom % NumParcels) * 8 +: 8];
        end
      end
      tabBundle[e] = makeBundle(parcels, 15'($urandom));
      tabOff[e] = $urandom % 8;
    end
  endtask

  // Reference model of the predecode rules
  task automatic buildExpected(input int idx);
    logic [BundleW-1:0] b;
    logic [NumParcels-1:0] ends;
    logic prevEnd;
    logic [7:0] op;
    logic [WindowParcels*ParcelW-1:0] win;
    instrSlotT iSlot;
    jumpSlotT jSlot;
    int nInstr;
    int nJump;
    int j;
    int len;
    b = tabBundle[idx];
    ends = b[EndBase +: NumParcels];
    ends[NumParcels-1] = 1'b1;
    prevEnd = 1'b1;
    nInstr = 0;
    nJump = 0;
    expInstrSlots[idx] = '0;
    expInstrEn[idx] = '0;
    expJumpSlots[idx] = '0;
    expJumpEn[idx] = '0;
    for (int k = 0; k < NumParcels; k++) begin
      if (prevEnd && k >= tabOff[idx]) begin
        j = k;
        while (!ends[j]) begin
          j++;
        end
        len = (j - k > 3) ? 3 : j - k;
        win = '0;
        for (int p = 0; p < WindowParcels; p++) begin
          if (k + p < NumParcels) begin
            win[p*ParcelW +: ParcelW] = b[(k+p)*ParcelW +: ParcelW];
          end
        end
        op = b[k*ParcelW +: 8];
        iSlot = '0;
        iSlot.window = win;
        iSlot.cls[ClsAlu] = (op[7:5] == 3'b000) || (op[7:3] == 5'b00100);
        iSlot.cls[ClsLoad] = (op[7:5] == 3'b010) && (op[0] == 1'b0);
        iSlot.cls[ClsStore] = (op[7:5] == 3'b010) && (op[0] == 1'b1);
        iSlot.cls[ClsJump] = (op[7:4] == 4'hA) || ((op >= 8'd178) && (op <= 8'd182));
        iSlot.len = len[1:0];
        iSlot.off = k[3:0];
        if (nInstr < NumInstrSlots) begin
          expInstrSlots[idx][nInstr] = iSlot;
          expInstrEn[idx][nInstr] = 1'b1;
        end
        nInstr++;
        if (iSlot.cls[ClsJump]) begin
          jSlot.window = win;
          jSlot.off = k[3:0];
          if (nJump < NumJumpSlots) begin
            expJumpSlots[idx][nJump] = jSlot;
            expJumpEn[idx][nJump] = 1'b1;
          end
          nJump++;
        end
      end
      prevEnd = ends[k];
    end
    expStartError[idx] = (tabOff[idx] == 15);
    expInstrOverflow[idx] = (nInstr > NumInstrSlots);
    expJumpOverflow[idx] = (nJump > NumJumpSlots);
  endtask

  task automatic applyEntry(input int idx);
    bundle = tabBundle[idx];
    startOff = 4'(tabOff[idx]);
    bundleValid = 1'b1;
  endtask

  task automatic checkIdle();
    checkValue("outValid", '0, CmpW'(outValid));
    checkValue("instrEn", '0, CmpW'(instrEn));
    checkValue("instrSlots", '0, CmpW'(instrSlots));
    checkValue("jumpEn", '0, CmpW'(jumpEn));
    checkValue("jumpSlots", '0, CmpW'(jumpSlots));
    checkValue("startError", '0, CmpW'(startError));
    checkValue("instrOverflow", '0, CmpW'(instrOverflow));
    checkValue("jumpOverflow", '0, CmpW'(jumpOverflow));
  endtask

  task automatic checkOutputs(input int idx, input logic expValid);
    checkValue("outValid", CmpW'(expValid), CmpW'(outValid));
    checkValue("instrEn", CmpW'(expInstrEn[idx]), CmpW'(instrEn));
    for (int s = 0; s < NumInstrSlots; s++) begin
      checkValue($sformatf("instrSlots[%0d]", s), CmpW'(expInstrSlots[idx][s]),
                 CmpW'(instrSlots[s]));
    end
    checkValue("jumpEn", CmpW'(expJumpEn[idx]), CmpW'(jumpEn));
    for (int s = 0; s < NumJumpSlots; s++) begin
      checkValue($sformatf("jumpSlots[%0d]", s), CmpW'(expJumpSlots[idx][s]),
                 CmpW'(jumpSlots[s]));
    end
    checkValue("startError", CmpW'(expStartError[idx]), CmpW'(startError));
    checkValue("instrOverflow", CmpW'(expInstrOverflow[idx]), CmpW'(instrOverflow));
    checkValue("jumpOverflow", CmpW'(expJumpOverflow[idx]), CmpW'(jumpOverflow));
  endtask

  initial begin
    rstN = 1'b0;
    bundleValid = 1'b0;
    bundle = '0;
    startOff = '0;
    void'($urandom(83));
    buildTable();
    for (int i = 0; i < NumEntries; i++) begin
      buildExpected(i);
    end

    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkIdle();

    // Data on the inputs but no strobe
    bundle = tabBundle[2];
    repeat (2) begin
      @(posedge clk);
      #1;
      checkIdle();
    end

    for (int i = 0; i < NumEntries; i++) begin
      @(posedge clk);
      #1;
      if (i > 0) begin
        checkOutputs(i - 1, 1'b0);
      end
      applyEntry(i);
      @(posedge clk);
      #1;
      bundleValid = 1'b0;
      checkOutputs(i, 1'b1);
    end

    // Back-to-back strobes
    @(posedge clk);
    #1;
    checkOutputs(NumEntries - 1, 1'b0);
    applyEntry(0);
    @(posedge clk);
    #1;
    applyEntry(8);
    checkOutputs(0, 1'b1);
    @(posedge clk);
    #1;
    bundleValid = 1'b0;
    checkOutputs(8, 1'b1);
    @(posedge clk);
    #1;
    checkOutputs(8, 1'b0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/predecodePkg.sv
design/parcelBoundary.sv
design/parcelClassifier.sv
design/slotCompactor.sv
design/bundlePredecoder.sv
sim/predecoderTb.sv

/* Makefile */
SRCS := design/predecodePkg.sv design/parcelBoundary.sv design/parcelClassifier.sv \
        design/slotCompactor.sv design/bundlePredecoder.sv sim/predecoderTb.sv

.PHONY: run clean

run: obj_dir/VpredecoderTb
	out="$$(./obj_dir/VpredecoderTb)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

obj_dir/VpredecoderTb: verilog.f $(SRCS)
	verilator --binary --top-module predecoderTb -f verilog.f

clean:
	rm -rf obj_dir
